// File: vlog.f
hw/scan_pkg.sv
hw/byte_if.sv
hw/credit_ingress.sv
hw/stream_tracker.sv
hw/sig_dfa.sv
hw/sig_channel.sv
hw/content_scanner.sv
verif/scanner_props.sv
verif/scanner_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the content scanner testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module scanner_tb \
   -f vlog.f \
   -o scanner_sim

./obj_dir/scanner_sim

// File: verif/scanner_tb.sv
`default_nettype none

module scanner_tb
   import scan_pkg::*;
;

   typedef count_t [NUM_SIGS-1:0] count_vec_t;

   logic       clk = 1'b0;
   logic       rst_n;
   logic       in_vld;
   char_t      in_data;
   logic       in_sop;
   logic       in_eop;
   stream_id_t in_stream;
   sig_mask_t  in_enable;
   logic       credit_ret;
   logic       res_vld;
   stream_id_t res_stream;
   sig_mask_t  res_fired;
   count_vec_t counts;

   // Source side credit view, returns may sit in pending for a while
   int         credits;
   int         pending;
   logic       slow_credits;
   logic       gap_on;

   // Reference model state, the saved positions survive reset like the DUT memory
   dfa_state_t ref_state [NUM_SIGS][NUM_STREAMS];
   logic       ref_seen [NUM_STREAMS];
   count_t     ref_count [NUM_SIGS];
   char_t      pkt_bytes [$];

   // Predicted results in packet order
   stream_id_t exp_stream_q [$];
   sig_mask_t  exp_mask_q [$];
   count_vec_t exp_count_q [$];
   count_vec_t exp_cnt;

   content_scanner i_content_scanner (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_vld     (in_vld),
      .in_data    (in_data),
      .in_sop     (in_sop),
      .in_eop     (in_eop),
      .in_stream  (in_stream),
      .in_enable  (in_enable),
      .credit_ret (credit_ret),
      .res_vld    (res_vld),
      .res_stream (res_stream),
      .res_fired  (res_fired),
      .counts     (counts)
   );

   always #5 clk = ~clk;

   task automatic fail_run(string msg);
      $display("%s", msg);
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped at first failure");
   endtask

   task automatic check_stream(stream_id_t got, stream_id_t exp);
      if (got !== exp)
         fail_run($sformatf("error %0t: res_stream %0d, expected %0d", $time, got, exp));
   endtask

   task automatic check_mask(sig_mask_t got, sig_mask_t exp);
      if (got !== exp)
         fail_run($sformatf("error %0t: res_fired %b, expected %b", $time, got, exp));
   endtask

   task automatic check_count(count_t got, count_t exp, int sig);
      if (got !== exp)
         fail_run($sformatf("error %0t: count %0d is %0d, expected %0d", $time, sig, got, exp));
   endtask

   // Matcher step: extend the prefix, else restart on the first character
   function automatic dfa_state_t next_prefix(int sig, char_t c, dfa_state_t st,
                                              output logic acc);
      acc = 1'b0;
      if (c == PATTERNS[sig][st])
      begin
         if (st == dfa_state_t'(PAT_LEN - 1))
         begin
            acc = 1'b1;
            return '0;
         end
         return st + 1'b1;
      end
      if (c == PATTERNS[sig][0])
         return dfa_state_t'(1);
      return '0;
   endfunction

   // Reference for one packet held in pkt_bytes
   function automatic void predict_packet(stream_id_t s, sig_mask_t en);
      dfa_state_t st;
      logic       acc;
      logic       flag;
      sig_mask_t  fired;
      count_vec_t cnt;
      fired = '0;
      for (int g = 0; g < NUM_SIGS; g++)
      begin
         // First packet of a stream since reset starts clean
         st   = ref_seen[s] ? ref_state[g][s] : '0;
         flag = 1'b0;
         foreach (pkt_bytes[i])
         begin
            st   = next_prefix(g, pkt_bytes[i], st, acc);
            flag = flag | acc;
         end
         if (en[g])
         begin
            fired[g]     = flag;
            ref_count[g] = ref_count[g] + count_t'(flag);
            ref_state[g][s] = st;
         end
         cnt[g] = ref_count[g];
      end
      ref_seen[s] = 1'b1;
      exp_stream_q.push_back(s);
      exp_mask_q.push_back(fired);
      exp_count_q.push_back(cnt);
   endfunction

   task automatic apply_reset();
      rst_n = 1'b0;
      repeat (16) @(posedge clk);
      #1;
      // Model forgets seen streams and counts, not saved positions
      foreach (ref_seen[i])
         ref_seen[i] = 1'b0;
      foreach (ref_count[g])
         ref_count[g] = '0;
      credits = FIFO_DEPTH;
      pending = 0;
      rst_n   = 1'b1;
   endtask

   task automatic send_beat(char_t c, logic sop, logic eop, stream_id_t s, sig_mask_t en);
      int waited;
      waited = 0;
      while (credits == 0 && waited < 100)
      begin
         @(posedge clk);
         #1;
         waited++;
      end
      if (credits == 0)
         fail_run("timeout: no credit came back to the source");
      else
      begin
         in_vld    = 1'b1;
         in_data   = c;
         in_sop    = sop;
         in_eop    = eop;
         in_stream = s;
         in_enable = en;
         credits   = credits - 1;
         @(posedge clk);
         #1;
         in_vld = 1'b0;
      end
   endtask

   task automatic send_packet(stream_id_t s, sig_mask_t en);
      predict_packet(s, en);
      foreach (pkt_bytes[i])
      begin
         // Optional idle cycle between beats
         if (gap_on && $urandom_range(0, 3) == 0)
         begin
            @(posedge clk);
            #1;
         end
         // Enable only counts on sop, later beats carry the inverse
         send_beat(pkt_bytes[i], i == 0, i == pkt_bytes.size() - 1, s,
                   (i == 0) ? en : ~en);
      end
   endtask

   task automatic load_text(string t);
      pkt_bytes.delete();
      for (int i = 0; i < t.len(); i++)
         pkt_bytes.push_back(char_t'(t[i]));
   endtask

   task automatic drain();
      int waited;
      waited = 0;
      while (exp_stream_q.size() != 0 && waited < 300)
      begin
         @(posedge clk);
         waited++;
      end
      if (exp_stream_q.size() != 0)
         fail_run("timeout: packet results still missing");
      else
      begin
         repeat (4) @(posedge clk);
         #1;
      end
   endtask

   // Credit returns counted mid cycle where credit_ret is stable
   always @(negedge clk)
   begin
      if (rst_n)
      begin
         if (credit_ret)
            pending = pending + 1;
         // Late credit release lets the source run dry
         if (!slow_credits || $urandom_range(0, 3) == 0)
         begin
            credits = credits + pending;
            pending = 0;
         end
      end
   end

   // Compare each result with the oldest prediction
   always @(negedge clk)
   begin
      if (rst_n && res_vld)
      begin
         if (exp_stream_q.size() == 0)
            fail_run("result reported with no packet pending");
         else
         begin
            check_stream(res_stream, exp_stream_q.pop_front());
            check_mask(res_fired, exp_mask_q.pop_front());
            exp_cnt = exp_count_q.pop_front();
            for (int g = 0; g < NUM_SIGS; g++)
               check_count(counts[g], exp_cnt[g], g);
         end
      end
   end

   initial
   begin
      stream_id_t s;
      sig_mask_t  en;
      int         len;
      string      alphabet;
      void'($urandom(32'ha369));
      alphabet     = "MAILRCPTZ";
      rst_n        = 1'b0;
      in_vld       = 1'b0;
      in_data      = '0;
      in_sop       = 1'b0;
      in_eop       = 1'b0;
      in_stream    = '0;
      in_enable    = '0;
      credits      = FIFO_DEPTH;
      pending      = 0;
      slow_credits = 1'b0;
      gap_on       = 1'b0;
      apply_reset();

      // Two hits in one packet count once
      load_text("xxMAILyyMAILz");
      send_packet(1, 2'b11);
      load_text("RCPTMAIL");
      send_packet(2, 2'b11);
      // Split across two packets of stream 3
      load_text("abMA");
      send_packet(3, 2'b11);
      load_text("ILq");
      send_packet(3, 2'b11);
      // Disabled tail of RCPT, then another stream, then the real tail
      load_text("zzRC");
      send_packet(4, 2'b11);
      load_text("PT");
      send_packet(4, 2'b00);
      load_text("RCPX");
      send_packet(6, 2'b11);
      load_text("PT");
      send_packet(4, 2'b11);
      // Partial MAI on stream 5 must not survive reset
      load_text("MAI");
      send_packet(5, 2'b11);
      drain();
      apply_reset();
      load_text("L");
      send_packet(5, 2'b11);
      drain();

      // Random traffic with gaps and held credits
      gap_on       = 1'b1;
      slow_credits = 1'b1;
      for (int n = 0; n < 300; n++)
      begin
         s  = stream_id_t'($urandom_range(0, 7));
         en = sig_mask_t'($urandom_range(0, 3));
         // Full mask on a stream's first packet keeps its saved state defined
         if (!ref_seen[s])
            en = '1;
         len = $urandom_range(1, 12);
         pkt_bytes.delete();
         for (int i = 0; i < len; i++)
            pkt_bytes.push_back(char_t'(alphabet[$urandom_range(0, 8)]));
         send_packet(s, en);
      end
      slow_credits = 1'b0;
      drain();

      if (credits + pending != FIFO_DEPTH)
         fail_run("credits lost: source did not get every credit back");
      else
      begin
         $display("SIMULATION PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: verif/scanner_props.sv
`default_nettype none

module scanner_props
   import scan_pkg::*;
(
   input logic clk,
   input logic rst_n,
   input logic in_vld,
   input logic credit_ret,
   input logic pop_vld,
   input logic pop_eop,
   input logic res_vld
);

   // Beats the source has spent and not yet got back
   int held;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         held <= 0;
      else
         held <= held + int'(in_vld) - int'(credit_ret);
   end

   a_credit_bound : assert property (@(posedge clk) disable iff (!rst_n)
      held <= FIFO_DEPTH)
      else $error("more beats outstanding than the ingress FIFO holds");

   // Popped eop leads to a result two cycles on
   a_result_after_eop : assert property (@(posedge clk) disable iff (!rst_n)
      (pop_vld && pop_eop) |-> ##2 res_vld)
      else $error("popped eop without a result two cycles later");

   a_credit_known : assert property (@(posedge clk) disable iff (!rst_n)
      !$isunknown(credit_ret))
      else $error("credit_ret unknown after reset");

endmodule

bind content_scanner scanner_props i_scanner_props (
   .clk        (clk),
   .rst_n      (rst_n),
   .in_vld     (in_vld),
   .credit_ret (credit_ret),
   .pop_vld    (link_ingress.vld),
   .pop_eop    (link_ingress.eop),
   .res_vld    (res_vld)
);

`default_nettype wire

// File: hw/content_scanner.sv
`default_nettype none

module content_scanner
   import scan_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    in_vld,
   input  char_t                   in_data,
   input  logic                    in_sop,
   input  logic                    in_eop,
   input  stream_id_t              in_stream,
   input  sig_mask_t               in_enable,
   output logic                    credit_ret,
   output logic                    res_vld,
   output stream_id_t              res_stream,
   output sig_mask_t               res_fired,
   output count_t [NUM_SIGS-1:0]   counts
);

   // Ingress to tracker
   byte_if link_ingress ();
   // Tracker to every channel
   byte_if link_track ();

   credit_ingress i_credit_ingress (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_vld     (in_vld),
      .in_data    (in_data),
      .in_sop     (in_sop),
      .in_eop     (in_eop),
      .in_stream  (in_stream),
      .in_enable  (in_enable),
      .credit_ret (credit_ret),
      .out        (link_ingress)
   );

   stream_tracker i_stream_tracker (
      .clk   (clk),
      .rst_n (rst_n),
      .in    (link_ingress),
      .out   (link_track)
   );

   // One matcher channel per signature, all fed the same beats
   for (genvar g = 0; g < NUM_SIGS; g++)
   begin : g_sig
      sig_channel #(
         .SIG (g)
      ) i_sig_channel (
         .clk   (clk),
         .rst_n (rst_n),
         .in    (link_track),
         .fired (res_fired[g]),
         .count (counts[g])
      );
   end

   // Result strobe lines up with the channel fired registers
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         res_vld <= 1'b0;
      else
         res_vld <= link_track.vld & link_track.eop;
   end

   // Stream of the packet that just ended
   always_ff @(posedge clk)
   begin
      if (link_track.vld && link_track.eop)
         res_stream <= link_track.stream;
   end

endmodule

`default_nettype wire

// File: hw/sig_channel.sv
`default_nettype none

module sig_channel
   import scan_pkg::*;
#(
   parameter int SIG = 0
) (
   input  logic   clk,
   input  logic   rst_n,
   byte_if.dst    in,
   output logic   fired,
   output count_t count
);

   // Matcher position saved at the end of each enabled packet
   dfa_state_t state_mem [NUM_STREAMS];

   // Position carried from one beat to the next inside a packet
   dfa_state_t run_state;
   dfa_state_t start_state;
   dfa_state_t next_state;
   logic       accept;

   // Packet saw at least one full match
   logic       match_flag;
   logic       flag_next;

   // Enable for this signature, latched on sop
   logic       pkt_en;
   logic       en_bit;

   // Pick where the matcher starts for this beat
   always_comb
   begin
      if (in.sop)
      begin
         // Fresh stream has no valid saved state
         if (in.new_stream)
            start_state = '0;
         else
            start_state = state_mem[in.stream];
      end
      else
         start_state = run_state;
   end

   // Flag restarts with each packet, a sop beat can set it right away
   assign flag_next = (match_flag & ~in.sop) | accept;

   // Enable is only sampled on sop, later beats use the latched copy
   assign en_bit = in.sop ? in.enable[SIG] : pkt_en;

   sig_dfa #(
      .SIG (SIG)
   ) i_sig_dfa (
      .char       (in.data),
      .state      (start_state),
      .next_state (next_state),
      .accept     (accept)
   );

   // Match flag, result and hit counter
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         match_flag <= 1'b0;
         fired      <= 1'b0;
         count      <= '0;
      end
      else
      begin
         // Result pulse only on the eop beat
         fired <= in.vld & in.eop & en_bit & flag_next;
         if (in.vld)
         begin
            match_flag <= flag_next;
            // One count per packet, however many matches it held
            if (in.eop && en_bit)
               count <= count + count_t'(flag_next);
         end
      end
   end

   // Running position, enable latch and per-stream save
   always_ff @(posedge clk)
   begin
      if (in.vld)
      begin
         run_state <= next_state;
         if (in.sop)
            pkt_en <= in.enable[SIG];
         // Disabled packets leave the stream state alone
         if (in.eop && en_bit)
            state_mem[in.stream] <= next_state;
      end
   end

endmodule

`default_nettype wire

// File: hw/sig_dfa.sv
`default_nettype none

module sig_dfa
   import scan_pkg::*;
#(
   parameter int SIG = 0
) (
   input  char_t      char,
   input  dfa_state_t state,
   output dfa_state_t next_state,
   output logic       accept
);

   // Signature this matcher looks for
   localparam char_t [0:PAT_LEN-1] PAT = PATTERNS[SIG];

   logic       hit;
   dfa_state_t adv;

   always_comb
   begin
      // Does the byte extend the current prefix
      hit = 1'b0;
      for (int i = 0; i < PAT_LEN; i++)
      begin
         if (state == dfa_state_t'(i))
            hit = (char == PAT[i]);
      end

      adv        = state + 1'b1;
      accept     = 1'b0;
      next_state = '0;

      if (hit)
      begin
         // Full pattern seen, start over
         if (adv == dfa_state_t'(PAT_LEN))
            accept = 1'b1;
         else
            next_state = adv;
      end
      // Mismatch may still start a new prefix
      // First char never recurs, so no deeper fallback exists
      else if (char == PAT[0])
         next_state = dfa_state_t'(1);
   end

endmodule

`default_nettype wire

// File: hw/stream_tracker.sv
`default_nettype none

module stream_tracker
   import scan_pkg::*;
(
   input  logic clk,
   input  logic rst_n,
   byte_if.dst  in,
   byte_if.src  out
);

   // One bit per stream id, set once the id has started a packet
   logic [NUM_STREAMS-1:0] seen;
   logic                   first_pkt;

   // First sop of an id since reset
   assign first_pkt = in.sop & ~seen[in.stream];

   // Seen table and output valid
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         seen    <= '0;
         out.vld <= 1'b0;
      end
      else
      begin
         out.vld <= in.vld;
         if (in.vld && in.sop)
            seen[in.stream] <= 1'b1;
      end
   end

   // Beat payload, one register stage
   always_ff @(posedge clk)
   begin
      out.data   <= in.data;
      out.sop    <= in.sop;
      out.eop    <= in.eop;
      out.stream <= in.stream;
      out.enable <= in.enable;
      // Channels only look at this on sop
      out.new_stream <= first_pkt;
   end

endmodule

`default_nettype wire

// File: hw/credit_ingress.sv
`default_nettype none

module credit_ingress
   import scan_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       in_vld,
   input  char_t      in_data,
   input  logic       in_sop,
   input  logic       in_eop,
   input  stream_id_t in_stream,
   input  sig_mask_t  in_enable,
   output logic       credit_ret,
   byte_if.src        out
);

   // Beat storage, one array per field
   char_t      data_mem   [FIFO_DEPTH];
   logic       sop_mem    [FIFO_DEPTH];
   logic       eop_mem    [FIFO_DEPTH];
   stream_id_t stream_mem [FIFO_DEPTH];
   sig_mask_t  enable_mem [FIFO_DEPTH];

   fifo_ptr_t   wr_ptr;
   fifo_ptr_t   rd_ptr;
   // Entries currently held
   credit_cnt_t level;
   logic        pop;

   // Drain one beat every cycle the buffer holds something
   assign pop = (level != '0);

   // Each pop hands one credit back to the source
   assign credit_ret = pop;

   // Head of the buffer goes out in the pop cycle
   assign out.vld    = pop;
   assign out.data   = data_mem[rd_ptr];
   assign out.sop    = sop_mem[rd_ptr];
   assign out.eop    = eop_mem[rd_ptr];
   assign out.stream = stream_mem[rd_ptr];
   assign out.enable = enable_mem[rd_ptr];
   // The tracker owns the stream marking
   assign out.new_stream = 1'b0;

   // Pointers and fill level
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level  <= '0;
      end
      else
      begin
         if (in_vld)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         // Credits bound the level to FIFO_DEPTH
         level <= level + credit_cnt_t'(in_vld) - credit_cnt_t'(pop);
      end
   end

   // Write side
   // A beat written now is visible to the read side next cycle
   always_ff @(posedge clk)
   begin
      if (in_vld)
      begin
         data_mem[wr_ptr]   <= in_data;
         sop_mem[wr_ptr]    <= in_sop;
         eop_mem[wr_ptr]    <= in_eop;
         stream_mem[wr_ptr] <= in_stream;
         enable_mem[wr_ptr] <= in_enable;
      end
   end

endmodule

`default_nettype wire

// File: hw/byte_if.sv
`default_nettype none

// One scanned byte plus the packet context it belongs to
interface byte_if
   import scan_pkg::*;
;

   // Qualifies every other field
   logic       vld;
   logic       sop;
   logic       eop;
   char_t      data;
   stream_id_t stream;
   // Only looked at on the sop beat
   sig_mask_t  enable;
   // Set by the tracker on the first sop of a stream
   logic       new_stream;

   modport src (output vld, sop, eop, data, stream, enable, new_stream);

   modport dst (input vld, sop, eop, data, stream, enable, new_stream);

endinterface

`default_nettype wire

// File: hw/scan_pkg.sv
`default_nettype none

package scan_pkg;

   // One byte of the reassembled stream
   typedef logic [7:0] char_t;

   // Stream identifier, also the index into the per-stream tables
   typedef logic [5:0] stream_id_t;

   // Every id has its own seen bit and saved matcher state
   localparam int NUM_STREAMS = 64;

   // Number of signature channels in the scanner
   localparam int NUM_SIGS = 2;

   // One bit per signature
   // Used for the per-packet enable and for the fired result
   typedef logic [NUM_SIGS-1:0] sig_mask_t;

   // Packets with a hit, per signature
   typedef logic [15:0] count_t;

   // All signatures have the same length
   localparam int PAT_LEN = 4;

   // Matched prefix length, 0 up to PAT_LEN-1 between bytes
   typedef logic [2:0] dfa_state_t;

   // Signature table, PATTERNS[sig][pos] with pos 0 the first character
   // The leftmost string lands at index 0
   // First character of each pattern does not repeat inside it
   localparam char_t [0:NUM_SIGS-1][0:PAT_LEN-1] PATTERNS = {
      "MAIL",
      "RCPT"
   };

   // Ingress buffer entries, equal to the credits the source starts with
   localparam int FIFO_DEPTH = 8;

   // Holds 0 up to FIFO_DEPTH
   typedef logic [$clog2(FIFO_DEPTH+1)-1:0] credit_cnt_t;

   // Read and write slot in the ingress buffer
   typedef logic [$clog2(FIFO_DEPTH)-1:0] fifo_ptr_t;

endpackage

`default_nettype wire
